//--- src/biu_macros.svh
`ifndef BIU_MACROS_SVH
`define BIU_MACROS_SVH

//////////////////////////////
// bus widths
//////////////////////////////

// data path, bits
`define BIU_XLEN 32

// byte address, bits
`define BIU_PLEN 32

//////////////////////////////
// subsystem sizing
//////////////////////////////

`define BIU_PORTS 2        // peer request ports on the mux

`define BIU_MEM_WORDS 256  // memory depth in XLEN words

`endif

//--- src/biu_pkg.sv
`include "biu_macros.svh"

package biu_pkg;

  //////////////////////////////
  // encodings
  //////////////////////////////

  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010
  } biu_size_e;

  // same order as AHB HBURST
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } biu_type_e;

  //////////////////////////////
  // request / response
  //////////////////////////////

  typedef struct packed {
    logic                 req;    // level, held until req_ack
    logic [`BIU_PLEN-1:0] adr;    // start address
    biu_size_e            size;
    biu_type_e            btype;
    logic                 we;
    logic [`BIU_XLEN-1:0] d;      // write data, byte lanes in place
  } biu_req_t;

  typedef struct packed {
    logic                 req_ack;  // one-cycle pulse
    logic                 ack;      // one per beat
    logic                 err;      // beat outside the array
    logic [`BIU_PLEN-1:0] adro;     // beat address
    logic [`BIU_XLEN-1:0] q;        // read data
  } biu_rsp_t;

  //////////////////////////////
  // burst helpers
  //////////////////////////////

  // beats minus one
  function automatic logic [3:0] biu_beats_m1(biu_type_e btype);
    case (btype)
      WRAP4, INCR4:   return 4'd3;
      WRAP8, INCR8:   return 4'd7;
      WRAP16, INCR16: return 4'd15;
      default:        return 4'd0;  // SINGLE, INCR
    endcase
  endfunction

  // word step, wraps inside beats*4 bytes for WRAPx
  function automatic logic [`BIU_PLEN-1:0] biu_next_adr(logic [`BIU_PLEN-1:0] adr,
                                                        biu_type_e btype);
    logic [`BIU_PLEN-1:0] mask;
    logic [`BIU_PLEN-1:0] inc;
    mask = (`BIU_PLEN'(biu_beats_m1(btype)) << 2) | `BIU_PLEN'(3);
    inc  = adr + `BIU_PLEN'(4);
    if (btype inside {WRAP4, WRAP8, WRAP16}) begin
      return (adr & ~mask) | (inc & mask);  // keep block, roll offset
    end
    return inc;
  endfunction

endpackage

//--- src/biu_port_mux.sv
`include "biu_macros.svh"

module biu_port_mux import biu_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  // peer ports
  input  biu_req_t [`BIU_PORTS-1:0]   port_req_i,
  output biu_rsp_t [`BIU_PORTS-1:0]   port_rsp_o,

  // shared bus towards memory
  output biu_req_t                    bus_req_o,
  input  biu_rsp_t                    bus_rsp_i
);

  localparam int PW = (`BIU_PORTS > 1) ? $clog2(`BIU_PORTS) : 1;

  typedef enum logic {
    IDLE,
    BURST
  } mux_state_e;

  //////////////////////////////
  // state
  //////////////////////////////

  mux_state_e        state_q;
  logic [3:0]        burst_cnt_q;      // beats left minus one
  logic [PW-1:0]     owner_q;          // port the beats belong to

  logic              pending_req;      // any port asking
  logic [PW-1:0]     pending_port;     // current winner
  logic [3:0]        pending_cnt;      // winner's beats minus one
  logic              last_beat;        // final ack of a running burst

  //////////////////////////////
  // arbitration
  //////////////////////////////

  always_comb begin
    pending_req = 1'b0;
    for (int n = 0; n < `BIU_PORTS; n++) begin
      pending_req = pending_req | port_req_i[n].req;
    end
  end

  // lowest index from 1 up wins, port 0 is the fallback
  always_comb begin
    pending_port = '0;
    for (int n = `BIU_PORTS - 1; n > 0; n--) begin
      if (port_req_i[n].req) begin
        pending_port = PW'(n);
      end
    end
  end

  assign pending_cnt = biu_beats_m1(port_req_i[pending_port].btype);
  assign last_beat   = (state_q == BURST) & bus_rsp_i.ack & (burst_cnt_q == 4'd0);

  //////////////////////////////
  // burst controller
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      burst_cnt_q <= '0;
      owner_q     <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          owner_q <= pending_port;  // single beat lands next cycle
          if (bus_rsp_i.req_ack && (pending_cnt != 4'd0)) begin
            state_q     <= BURST;
            burst_cnt_q <= pending_cnt;
          end
        end
        BURST: begin
          if (bus_rsp_i.ack) begin
            burst_cnt_q <= burst_cnt_q - 4'd1;
            if (burst_cnt_q == 4'd0) begin
              owner_q <= pending_port;  // hand over at the last beat
              if (bus_rsp_i.req_ack && (pending_cnt != 4'd0)) begin
                burst_cnt_q <= pending_cnt;  // back to back burst
              end else begin
                state_q <= IDLE;
              end
            end
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // request path
  //////////////////////////////

  always_comb begin
    bus_req_o = port_req_i[pending_port];  // attributes from the winner
    if (state_q == IDLE) begin
      bus_req_o.req = pending_req;
    end else begin
      bus_req_o.req = last_beat & pending_req;  // overlap next start with last beat
    end
    // memory writes each beat in its ack cycle, so data tracks the owner there
    if (bus_rsp_i.ack) begin
      bus_req_o.d = port_req_i[owner_q].d;
    end
  end

  //////////////////////////////
  // response decode
  //////////////////////////////

  always_comb begin
    for (int p = 0; p < `BIU_PORTS; p++) begin
      port_rsp_o[p].req_ack = (PW'(p) == pending_port) & bus_rsp_i.req_ack;
      port_rsp_o[p].ack     = (PW'(p) == owner_q) & bus_rsp_i.ack;
      port_rsp_o[p].err     = (PW'(p) == owner_q) & bus_rsp_i.err;
      port_rsp_o[p].adro    = bus_rsp_i.adro;  // broadcast, qualified by ack
      port_rsp_o[p].q       = bus_rsp_i.q;
    end
  end

endmodule

//--- src/biu_mem.sv
`include "biu_macros.svh"

module biu_mem import biu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  biu_req_t req_i,
  output biu_rsp_t rsp_o
);

  localparam int IW = $clog2(`BIU_MEM_WORDS);
  localparam int NB = `BIU_XLEN / 8;

  //////////////////////////////
  // storage and beat state
  //////////////////////////////

  logic [`BIU_XLEN-1:0] mem_array [`BIU_MEM_WORDS];

  logic                 active_q;      // beats outstanding
  logic [3:0]           beat_cnt_q;    // beats left minus one
  logic [`BIU_PLEN-1:0] cur_adr_q;     // address of this cycle's beat
  biu_size_e            cur_size_q;
  biu_type_e            cur_btype_q;   // for the address step
  logic                 cur_we_q;

  logic                 last_beat;
  logic                 accept;
  logic                 in_range;
  logic [IW-1:0]        word_idx;
  logic [NB-1:0]        lane_en;

  assign last_beat = active_q & (beat_cnt_q == 4'd0);
  assign accept    = req_i.req & (~active_q | last_beat);  // idle or finishing

  assign in_range  = cur_adr_q[`BIU_PLEN-1:2] < (`BIU_PLEN-2)'(`BIU_MEM_WORDS);
  assign word_idx  = cur_adr_q[2 +: IW];

  // byte lanes from size and low address bits
  always_comb begin
    case (cur_size_q)
      BYTE:    lane_en = NB'(1) << cur_adr_q[1:0];
      HWORD:   lane_en = NB'(3) << {cur_adr_q[1], 1'b0};
      default: lane_en = '1;
    endcase
  end

  //////////////////////////////
  // sequencing
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q   <= 1'b0;
      beat_cnt_q <= '0;
    end else if (accept) begin
      active_q   <= 1'b1;
      beat_cnt_q <= biu_beats_m1(req_i.btype);
    end else if (active_q) begin
      if (last_beat) begin
        active_q <= 1'b0;
      end else begin
        beat_cnt_q <= beat_cnt_q - 4'd1;
      end
    end
  end

  // attributes latched on accept, address walks per beat
  always_ff @(posedge clk_i) begin
    if (accept) begin
      cur_adr_q   <= req_i.adr;
      cur_size_q  <= req_i.size;
      cur_btype_q <= req_i.btype;
      cur_we_q    <= req_i.we;
    end else if (active_q) begin
      cur_adr_q <= biu_next_adr(cur_adr_q, cur_btype_q);
    end
  end

  //////////////////////////////
  // array access
  //////////////////////////////

  // write lands in the beat's own cycle, out of range beats skipped
  always_ff @(posedge clk_i) begin
    if (active_q && cur_we_q && in_range) begin
      for (int b = 0; b < NB; b++) begin
        if (lane_en[b]) begin
          mem_array[word_idx][8*b +: 8] <= req_i.d[8*b +: 8];
        end
      end
    end
  end

  assign rsp_o.req_ack = accept;
  assign rsp_o.ack     = active_q;               // one beat per active cycle
  assign rsp_o.err     = active_q & ~in_range;
  assign rsp_o.adro    = cur_adr_q;
  assign rsp_o.q       = (active_q && in_range) ? mem_array[word_idx] : '0;  // zero on err

endmodule

//--- src/biu_subsys_top.sv
`include "biu_macros.svh"

module biu_subsys_top import biu_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // peer ports, driven from outside
  input  biu_req_t [`BIU_PORTS-1:0] port_req_i,
  output biu_rsp_t [`BIU_PORTS-1:0] port_rsp_o
);

  //////////////////////////////
  // shared bus
  //////////////////////////////

  biu_req_t bus_req;   // mux -> memory
  biu_rsp_t bus_rsp;   // memory -> mux

  // arbitration, burst hold, response steering
  biu_port_mux biu_port_mux_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .port_req_i (port_req_i),
    .port_rsp_o (port_rsp_o),
    .bus_req_o  (bus_req),
    .bus_rsp_i  (bus_rsp)
  );

  // stand-in for the AHB side
  biu_mem biu_mem_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (bus_req),
    .rsp_o  (bus_rsp)
  );

endmodule

//--- dv/biu_scoreboard.sv
`include "biu_macros.svh"

module biu_scoreboard import biu_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  biu_req_t [`BIU_PORTS-1:0] port_req_i,
  input  biu_rsp_t [`BIU_PORTS-1:0] port_rsp_i,
  output int                        mismatch_o,
  output int                        beat_cnt_o
);

  logic [31:0] ref_mem [`BIU_MEM_WORDS];
  bit          ref_valid [`BIU_MEM_WORDS];  // word fully written once

  // per-port transfer context
  bit          busy [`BIU_PORTS];
  logic [31:0] cur_adr [`BIU_PORTS];
  biu_size_e   cur_size [`BIU_PORTS];
  biu_type_e   cur_type [`BIU_PORTS];
  logic        cur_we [`BIU_PORTS];
  int          left [`BIU_PORTS];

  //////////////////////////////
  // reference functions
  //////////////////////////////

  function automatic int burst_len(biu_type_e bt);
    case (bt)
      WRAP4, INCR4:   return 4;
      WRAP8, INCR8:   return 8;
      WRAP16, INCR16: return 16;
      default:        return 1;
    endcase
  endfunction

  function automatic logic [31:0] expect_next_adr(logic [31:0] adr, biu_type_e bt);
    logic [31:0] blk;
    logic [31:0] base;
    blk = 32'(burst_len(bt) * 4);
    if (bt == WRAP4 || bt == WRAP8 || bt == WRAP16) begin
      base = adr - (adr % blk);
      return base + ((adr - base + 32'd4) % blk);  // roll inside block
    end
    return adr + 32'd4;
  endfunction

  // new word after a sized write
  function automatic logic [31:0] merge_lanes(logic [31:0] old, logic [31:0] d,
                                              biu_size_e size, logic [1:0] off);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (size == WORD || (size == HWORD && b / 2 == off / 2) || b == int'(off)) begin
        res[8*b +: 8] = d[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic report(int p, string msg);
    $display("ERROR %0t: port %0d %s", $time, p, msg);
    mismatch_o++;
  endtask

  //////////////////////////////
  // compare every beat
  //////////////////////////////

  initial begin
    mismatch_o = 0;
    beat_cnt_o = 0;
    for (int p = 0; p < `BIU_PORTS; p++) busy[p] = 0;
    for (int w = 0; w < `BIU_MEM_WORDS; w++) ref_valid[w] = 0;
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      for (int p = 0; p < `BIU_PORTS; p++) begin
        if (port_rsp_i[p].ack) begin
          logic exp_err;
          int   idx;
          beat_cnt_o++;
          idx     = int'(cur_adr[p][31:2]);
          exp_err = cur_adr[p][31:2] >= 30'(`BIU_MEM_WORDS);
          if (!busy[p]) begin
            report(p, "ack with no transfer owned");
          end else begin
            if (port_rsp_i[p].adro !== cur_adr[p]) begin
              report(p, $sformatf("adro %h, expected %h", port_rsp_i[p].adro, cur_adr[p]));
            end
            if (port_rsp_i[p].err !== exp_err) begin
              report(p, $sformatf("err %b at %h", port_rsp_i[p].err, cur_adr[p]));
            end
            if (exp_err) begin
              if (port_rsp_i[p].q !== '0) report(p, "nonzero q on error beat");
            end else if (cur_we[p]) begin
              ref_mem[idx] = merge_lanes(ref_mem[idx], port_req_i[p].d, cur_size[p],
                                         cur_adr[p][1:0]);
              if (cur_size[p] == WORD) ref_valid[idx] = 1;
            end else if (ref_valid[idx] && port_rsp_i[p].q !== ref_mem[idx]) begin
              report(p, $sformatf("q %h at %h, expected %h", port_rsp_i[p].q,
                                  cur_adr[p], ref_mem[idx]));
            end
            cur_adr[p] = expect_next_adr(cur_adr[p], cur_type[p]);
            if (left[p] == 0) busy[p] = 0;
            else left[p]--;
          end
        end
        if (port_rsp_i[p].req_ack) begin  // new transfer starts
          busy[p]     = 1;
          cur_adr[p]  = port_req_i[p].adr;
          cur_size[p] = port_req_i[p].size;
          cur_type[p] = port_req_i[p].btype;
          cur_we[p]   = port_req_i[p].we;
          left[p]     = burst_len(port_req_i[p].btype) - 1;
        end
      end
    end
  end

endmodule

//--- dv/biu_chk.sv
`include "biu_macros.svh"

module biu_chk import biu_pkg::*; (
  input logic                      clk_i,
  input logic                      rst_ni,
  input biu_rsp_t [`BIU_PORTS-1:0] port_rsp_o,
  input biu_req_t                  bus_req_o,
  input biu_rsp_t                  bus_rsp_i
);

  logic [`BIU_PORTS-1:0] req_ack_vec;       // per-port grant pulses
  logic [`BIU_PORTS-1:0] granted_q;         // port holding the latest grant
  int                    assert_fails = 0;  // failed assertions so far

  always_comb begin
    for (int p = 0; p < `BIU_PORTS; p++) begin
      req_ack_vec[p] = port_rsp_o[p].req_ack;
    end
  end

  // a new grant moves ownership, beats of the old one are done by then
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      granted_q <= '0;
    end else if (|req_ack_vec) begin
      granted_q <= req_ack_vec;
    end
  end

  //////////////////////////////
  // bus side properties
  //////////////////////////////

  a_one_req_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(req_ack_vec)) else begin
    $error("more than one req_ack in a cycle");
    assert_fails++;
  end

  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bus_req_o.req && !bus_rsp_i.req_ack) |=> bus_req_o.req) else begin
    $error("bus request dropped before req_ack");
    assert_fails++;
  end

  for (genvar p = 0; p < `BIU_PORTS; p++) begin : g_ack
    a_ack_after_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
      port_rsp_o[p].ack |-> granted_q[p]) else begin
      $error("ack to a port without the latest req_ack");
      assert_fails++;
    end
  end

endmodule

bind biu_port_mux biu_chk biu_chk_inst (.*);

//--- dv/biu_tb.sv
`include "biu_macros.svh"

module biu_tb import biu_pkg::*; ();

  localparam int TIMEOUT = 100;  // cycles per wait

  logic                      clk_i;
  logic                      rst_ni;
  biu_req_t [`BIU_PORTS-1:0] port_req;
  biu_rsp_t [`BIU_PORTS-1:0] port_rsp;
  int                        mismatches;
  int                        beats_seen;

  int  n_pass, n_fail, test_err, last_mm;
  time grant_time [`BIU_PORTS];
  time last_ack_time [`BIU_PORTS];

  always #10 clk_i = ~clk_i;

  biu_subsys_top biu_subsys_top_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .port_req_i (port_req),
    .port_rsp_o (port_rsp)
  );

  biu_scoreboard biu_scoreboard_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .port_req_i (port_req),
    .port_rsp_i (port_rsp),
    .mismatch_o (mismatches),
    .beat_cnt_o (beats_seen)
  );

  // grant and beat timing, for the arbitration tests
  always @(posedge clk_i) begin
    for (int p = 0; p < `BIU_PORTS; p++) begin
      if (port_rsp[p].req_ack) grant_time[p] = $time;
      if (port_rsp[p].ack) last_ack_time[p] = $time;
    end
  end

  task automatic end_run(bit ok);
    if (ok) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic close_test(string name);
    int bad;
    bad     = test_err + (mismatches - last_mm);
    last_mm = mismatches;
    test_err = 0;
    if (bad == 0) n_pass++;
    else n_fail++;
    $display("%s: %s (%0d errors)", name, (bad == 0) ? "ok" : "FAIL", bad);
  endtask

  //////////////////////////////
  // port driver
  //////////////////////////////

  task automatic run_access(input int p, input logic [31:0] adr, input biu_size_e size,
                            input biu_type_e bt, input logic we, input logic [31:0] wd [16],
                            input int n_exp, output int beats, output int errs);
    int  cyc;
    bit  hit;
    bit  e;
    beats = 0;
    errs  = 0;
    port_req[p].adr   = adr;
    port_req[p].size  = size;
    port_req[p].btype = bt;
    port_req[p].we    = we;
    port_req[p].d     = wd[0];
    port_req[p].req   = 1'b1;
    cyc = 0;
    hit = 0;
    while (!hit) begin
      @(posedge clk_i);
      hit = port_rsp[p].req_ack;  // grant taken at this edge
      if (++cyc > TIMEOUT) begin
        $display("port %0d stalled, no req_ack within %0d cycles", p, TIMEOUT);
        end_run(0);
      end
    end
    cyc = 0;
    while (beats < n_exp) begin
      @(negedge clk_i);
      hit = port_rsp[p].ack;  // sample before driving
      e   = port_rsp[p].err;
      port_req[p].req = 1'b0;
      port_req[p].d   = wd[beats];  // data for the beat in flight
      if (hit) begin
        beats++;
        if (e) errs++;
      end
      if (++cyc > TIMEOUT) begin
        $display("port %0d stalled after %0d of %0d beats", p, beats, n_exp);
        end_run(0);
      end
    end
  endtask

  task automatic check_beats(int got, int exp);
    if (got != exp) begin
      $display("ERROR %0t: %0d beats, expected %0d", $time, got, exp);
      test_err++;
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  initial begin
    logic [31:0] wd [16];
    biu_type_e   types [6];
    int          lens [6];
    int          nb, ne, nb1, ne1;
    int          chk_fails;
    types = '{INCR4, INCR8, INCR16, WRAP4, WRAP8, WRAP16};
    lens  = '{4, 8, 16, 4, 8, 16};
    void'($urandom(32'he2581b5b));
    clk_i = 0;
    rst_ni = 0;
    port_req = '0;
    n_pass = 0;
    n_fail = 0;
    test_err = 0;
    last_mm = 0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1;
    @(negedge clk_i);

    for (int p = 0; p < 2; p++) begin  // single words, both ports
      for (int i = 0; i < 4; i++) begin
        foreach (wd[k]) wd[k] = $urandom;
        run_access(p, 32'(p * 32 + i * 4), WORD, SINGLE, 1, wd, 1, nb, ne);
        run_access(p, 32'(p * 32 + i * 4), WORD, SINGLE, 0, wd, 1, nb, ne);
        check_beats(nb, 1);
      end
    end
    close_test("test 1 single write/read");

    for (int i = 0; i < 4; i++) begin
      foreach (wd[k]) wd[k] = $urandom;
      run_access(0, 32'h40 + 32'(i * 4), WORD, SINGLE, 1, wd, 1, nb, ne);
    end
    for (int i = 0; i < 12; i++) begin  // random lanes
      biu_size_e sz;
      logic [31:0] a;
      foreach (wd[k]) wd[k] = $urandom;
      sz = ($urandom % 2) ? HWORD : BYTE;
      a  = 32'h40 + ($urandom % 16);
      if (sz == HWORD) a[0] = 1'b0;
      run_access(i % 2, a, sz, SINGLE, 1, wd, 1, nb, ne);
    end
    for (int i = 0; i < 4; i++) begin
      run_access(1, 32'h40 + 32'(i * 4), WORD, SINGLE, 0, wd, 1, nb, ne);
    end
    close_test("test 2 byte/halfword lanes");

    for (int t = 0; t < 6; t++) begin  // bursts, wrap starts mid block
      foreach (wd[k]) wd[k] = $urandom;
      run_access(1, 32'h100 + 32'(t * 64) + 32'h8, WORD, types[t], 1, wd, lens[t], nb, ne);
      check_beats(nb, lens[t]);
      run_access(1, 32'h100 + 32'(t * 64) + 32'h8, WORD, types[t], 0, wd, lens[t], nb, ne);
      check_beats(nb, lens[t]);
    end
    close_test("test 3 INCR/WRAP bursts");

    fork
      run_access(0, 32'h0, WORD, SINGLE, 0, wd, 1, nb, ne);
      run_access(1, 32'h20, WORD, SINGLE, 0, wd, 1, nb1, ne1);
    join
    check_beats(nb, 1);
    check_beats(nb1, 1);
    if (grant_time[1] >= grant_time[0]) begin
      $display("ERROR %0t: port 0 granted before port 1", $time);
      test_err++;
    end
    close_test("test 4 simultaneous requests");

    fork
      begin
        run_access(0, 32'h100, WORD, INCR8, 0, wd, 8, nb, ne);
        check_beats(nb, 8);
      end
      begin
        repeat (3) @(negedge clk_i);
        run_access(1, 32'h0, WORD, SINGLE, 0, wd, 1, nb1, ne1);
        check_beats(nb1, 1);
      end
    join
    if (grant_time[1] != last_ack_time[0]) begin
      $display("ERROR %0t: port 1 granted at %0t, last burst beat at %0t", $time,
               grant_time[1], last_ack_time[0]);
      test_err++;
    end
    close_test("test 5 burst then late request");

    foreach (wd[k]) wd[k] = $urandom;
    run_access(0, 32'h400, WORD, SINGLE, 1, wd, 1, nb, ne);  // aliases word 0
    check_beats(ne, 1);
    run_access(1, 32'h508, WORD, INCR4, 1, wd, 4, nb, ne);   // aliases 0x108..0x114
    check_beats(ne, 4);
    run_access(0, 32'h3f8, WORD, INCR4, 0, wd, 4, nb, ne);   // straddles the end
    check_beats(ne, 2);
    run_access(1, 32'h0, WORD, SINGLE, 0, wd, 1, nb, ne);
    run_access(0, 32'h10c, WORD, SINGLE, 0, wd, 1, nb, ne);
    close_test("test 6 out of range");

    chk_fails = biu_subsys_top_inst.biu_port_mux_inst.biu_chk_inst.assert_fails;
    $display("tests: %0d passed, %0d failed, %0d beats checked, %0d assertion failures",
             n_pass, n_fail, beats_seen, chk_fails);
    end_run(n_fail == 0 && chk_fails == 0);
  end

endmodule

//--- compile.f
+incdir+src
src/biu_pkg.sv
src/biu_port_mux.sv
src/biu_mem.sv
src/biu_subsys_top.sv
dv/biu_scoreboard.sv
dv/biu_chk.sv
dv/biu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= biu_tb
FILELIST  ?= compile.f
PASS_MSG  ?= Test passed
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
